// ==== Bender.yml ====
package:
  name: board_game

sources:
  - game_pkg.sv
  - ctrl_pkg.sv
  - tick_divider.sv
  - cursor_box.sv
  - board_ram.sv
  - move_checker.sv
  - game_control.sv
  - game_top.sv
  - target: simulation
    files:
      - tb_game_top.sv

// ==== board_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

module board_ram
  import game_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic wr_en,
  input  logic [coord_w-1:0] wr_x,
  input  logic [coord_w-1:0] wr_y,
  input  logic [piece_w-1:0] wr_piece,
  input  logic [coord_w-1:0] a_x,
  input  logic [coord_w-1:0] a_y,
  output logic [piece_w-1:0] a_piece,
  input  logic [coord_w-1:0] b_x,
  input  logic [coord_w-1:0] b_y,
  output logic [piece_w-1:0] b_piece,
  input  logic [coord_w-1:0] c_x,
  input  logic [coord_w-1:0] c_y,
  output logic [piece_w-1:0] c_piece
);

  localparam int cells = board_dim * board_dim;

  // cell index is {y, x}
  logic [piece_w-1:0] mem [cells];

  function automatic logic [piece_w-1:0] layout_piece(input int idx);
    logic [piece_w-1:0] code;
    logic owner;
    int x;
    int y;
    code = piece_empty;
    x = idx % board_dim;
    y = idx / board_dim;
    owner = (y == board_dim - 1);
    if (y == 0 || y == board_dim - 1) begin
      if (x == 0 || x == board_dim - 1) code = {owner, kind_rook};
      else if (x == 4) code = {owner, kind_king};
    end
    return code;
  endfunction

  always_ff @(posedge clk) begin
    if (reset) begin
      for (int i = 0; i < cells; i++) mem[i] <= layout_piece(i);
    end else if (wr_en) begin
      mem[{wr_y, wr_x}] <= wr_piece;
    end
  end

  assign a_piece = mem[{a_y, a_x}];
  assign b_piece = mem[{b_y, b_x}];
  assign c_piece = mem[{c_y, c_x}];

  a_known_kind: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> wr_piece[2:0] inside {kind_empty, kind_king, kind_rook}
  );

endmodule

`default_nettype wire

// ==== ctrl_pkg.sv ====
`default_nettype none

package ctrl_pkg;

  typedef enum logic [3:0] {
    S_INIT,
    S_MOVE_BOX_1,
    S_SELECT_PIECE,
    S_VALIDATE_PIECE,
    S_MOVE_BOX_2,
    S_SELECT_DESTINATION,
    S_VALIDATE_DESTINATION,
    S_COMMIT_SRC,
    S_COMMIT_DST,
    S_CHECK_WINNING,
    S_GAME_OVER
  } ctrl_state_e;

  // answer of the move checker, held until the next check
  typedef enum logic [1:0] {
    verdict_none,
    verdict_legal,
    verdict_illegal
  } verdict_e;

endpackage

`default_nettype wire

// ==== cursor_box.sv ====
`timescale 1ns/1ps
`default_nettype none

module cursor_box
  import game_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic tick,
  input  logic box_enable,
  input  logic up,
  input  logic down,
  input  logic left,
  input  logic right,
  output logic [coord_w-1:0] box_x,
  output logic [coord_w-1:0] box_y
);

  // coordinates wrap through the natural width of coord_w
  always_ff @(posedge clk) begin
    if (reset) begin
      box_x <= '0;
      box_y <= '0;
    end else if (tick && box_enable) begin
      // right beats left, up beats down
      if (right) begin
        box_x <= box_x + 1'b1;
      end else if (left) begin
        box_x <= box_x - 1'b1;
      end
      if (up) begin
        box_y <= box_y + 1'b1;
      end else if (down) begin
        box_y <= box_y - 1'b1;
      end
    end
  end

  a_still_without_tick: assert property (
    @(posedge clk) disable iff (reset)
    !(tick && box_enable) |=> $stable(box_x) && $stable(box_y)
  );

endmodule

`default_nettype wire

// ==== flist.f ====
game_pkg.sv
ctrl_pkg.sv
tick_divider.sv
cursor_box.sv
board_ram.sv
move_checker.sv
game_control.sv
game_top.sv
tb_game_top.sv

// ==== game_cases.txt ====
# one move attempt per line, cells given as x then y, player zero moves first
# columns: src_x src_y dst_x dst_y legal win
4 0 4 2 0 0
0 0 1 1 0 0
0 0 4 0 0 0
0 0 6 0 0 0
0 0 0 5 1 0
0 7 0 2 0 0
0 7 0 5 1 0
4 0 5 1 1 0
4 7 4 6 1 0
7 0 7 7 1 0
0 5 5 5 1 0
5 1 5 1 0 0
7 7 7 6 1 0
5 5 5 1 1 1

// ==== game_control.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_control
  import game_pkg::*;
  import ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic select,
  input  logic deselect,
  input  logic [piece_w-1:0] cursor_piece,
  input  logic [coord_w-1:0] box_x,
  input  logic [coord_w-1:0] box_y,
  input  verdict_e verdict,
  input  logic [piece_w-1:0] captured,
  input  logic done,
  output logic box_enable,
  output logic check_start,
  output logic [coord_w-1:0] src_x,
  output logic [coord_w-1:0] src_y,
  output logic [coord_w-1:0] dst_x,
  output logic [coord_w-1:0] dst_y,
  output logic [piece_w-1:0] piece,
  output logic current_player,
  output logic [1:0] winning,
  output logic wr_en,
  output logic [coord_w-1:0] wr_x,
  output logic [coord_w-1:0] wr_y,
  output logic [piece_w-1:0] wr_piece
);

  ctrl_state_e state, next_state;
  logic done_seen;
  logic piece_valid;
  logic king_taken;

  assign piece_valid = (piece != piece_empty) && (piece[3] == current_player);
  assign king_taken = (piece_kind_e'(captured[2:0]) == kind_king) &&
                      (captured[3] != current_player);

  always_comb begin
    next_state = state;
    case (state)
      S_INIT: next_state = S_MOVE_BOX_1;
      S_MOVE_BOX_1: if (select) next_state = S_SELECT_PIECE;
      S_SELECT_PIECE: next_state = S_VALIDATE_PIECE;
      // wait for select to fall so one press is one action
      S_VALIDATE_PIECE: if (!select) next_state = piece_valid ? S_MOVE_BOX_2 : S_MOVE_BOX_1;
      S_MOVE_BOX_2: begin
        if (deselect) begin
          if (!select) next_state = S_MOVE_BOX_1;
        end else if (select) begin
          next_state = S_SELECT_DESTINATION;
        end
      end
      S_SELECT_DESTINATION: next_state = S_VALIDATE_DESTINATION;
      S_VALIDATE_DESTINATION: begin
        if (done_seen && !select)
          next_state = (verdict == verdict_legal) ? S_COMMIT_SRC : S_MOVE_BOX_2;
      end
      S_COMMIT_SRC: next_state = S_COMMIT_DST;
      S_COMMIT_DST: next_state = S_CHECK_WINNING;
      S_CHECK_WINNING: next_state = king_taken ? S_GAME_OVER : S_MOVE_BOX_1;
      S_GAME_OVER: next_state = S_GAME_OVER;
      default: next_state = S_INIT;
    endcase
  end

  always_ff @(posedge clk) begin
    if (reset) state <= S_INIT;
    else state <= next_state;
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      piece <= piece_empty;
      current_player <= 1'b0;
      winning <= 2'b00;
      done_seen <= 1'b0;
    end else begin
      if (state == S_SELECT_PIECE) begin
        piece <= cursor_piece;
        src_x <= box_x;
        src_y <= box_y;
      end
      // every way back to the first box state drops the held piece
      if (next_state == S_MOVE_BOX_1) piece <= piece_empty;
      if (state == S_MOVE_BOX_2 && next_state == S_SELECT_DESTINATION) begin
        dst_x <= box_x;
        dst_y <= box_y;
      end
      if (state == S_SELECT_DESTINATION) done_seen <= 1'b0;
      else if (done) done_seen <= 1'b1;
      if (state == S_CHECK_WINNING) begin
        if (king_taken) winning <= {1'b1, current_player};
        else current_player <= ~current_player;
      end
    end
  end

  assign box_enable = (state == S_MOVE_BOX_1) || (state == S_MOVE_BOX_2);
  assign check_start = (state == S_SELECT_DESTINATION);

  // source is cleared first, then the piece lands
  assign wr_en = (state == S_COMMIT_SRC) || (state == S_COMMIT_DST);
  assign wr_x = (state == S_COMMIT_SRC) ? src_x : dst_x;
  assign wr_y = (state == S_COMMIT_SRC) ? src_y : dst_y;
  assign wr_piece = (state == S_COMMIT_SRC) ? piece_empty : piece;

  // a board write only ever follows a finished legal check
  a_write_in_commit: assert property (
    @(posedge clk) disable iff (reset)
    wr_en |-> done_seen && verdict == verdict_legal
  );

endmodule

`default_nettype wire

// ==== game_pkg.sv ====
`default_nettype none

package game_pkg;

  // board geometry
  localparam int board_dim = 8;
  localparam int coord_w = 3;

  // piece code is {owner, kind}, owner 0 is player zero
  localparam int piece_w = 4;

  typedef enum logic [2:0] {
    kind_empty = 3'd0,
    kind_king  = 3'd1,
    kind_rook  = 3'd2
  } piece_kind_e;

  localparam logic [piece_w-1:0] piece_empty = '0;

  // reset layout
  // rows 0 and 7 hold rook, king, rook at columns 0, 4, 7
  // row 0 belongs to player zero, row 7 to player one
  // every other cell starts empty

endpackage

`default_nettype wire

// ==== game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module game_top
  import game_pkg::*;
  import ctrl_pkg::*;
#(
  parameter int TICK_DIV = 12500000
) (
  input  logic clk,
  input  logic reset,
  input  logic up,
  input  logic down,
  input  logic left,
  input  logic right,
  input  logic select,
  input  logic deselect,
  output logic [coord_w-1:0] box_x,
  output logic [coord_w-1:0] box_y,
  output logic [piece_w-1:0] piece,
  output logic current_player,
  output logic [1:0] winning,
  input  logic [coord_w-1:0] probe_x,
  input  logic [coord_w-1:0] probe_y,
  output logic [piece_w-1:0] probe_piece
);

  logic tick, box_enable, check_start, done, wr_en;
  logic [coord_w-1:0] walk_x, walk_y, wr_x, wr_y;
  logic [coord_w-1:0] src_x, src_y, dst_x, dst_y;
  logic [piece_w-1:0] cursor_piece, walk_piece, wr_piece, captured;
  verdict_e verdict;

  tick_divider #(.TICK_DIV(TICK_DIV)) tick_divider_inst (
    .clk(clk), .reset(reset), .tick(tick)
  );

  cursor_box cursor_box_inst (
    .clk(clk), .reset(reset), .tick(tick), .box_enable(box_enable),
    .up(up), .down(down), .left(left), .right(right),
    .box_x(box_x), .box_y(box_y)
  );

  // port a follows the box, b the checker walk, c the probe
  board_ram board_ram_inst (
    .clk(clk), .reset(reset),
    .wr_en(wr_en), .wr_x(wr_x), .wr_y(wr_y), .wr_piece(wr_piece),
    .a_x(box_x), .a_y(box_y), .a_piece(cursor_piece),
    .b_x(walk_x), .b_y(walk_y), .b_piece(walk_piece),
    .c_x(probe_x), .c_y(probe_y), .c_piece(probe_piece)
  );

  move_checker move_checker_inst (
    .clk(clk), .reset(reset), .check_start(check_start),
    .src_x(src_x), .src_y(src_y), .dst_x(dst_x), .dst_y(dst_y),
    .mover(piece), .player(current_player), .walk_piece(walk_piece),
    .walk_x(walk_x), .walk_y(walk_y), .verdict(verdict),
    .captured(captured), .done(done)
  );

  game_control game_control_inst (
    .clk(clk), .reset(reset), .select(select), .deselect(deselect),
    .cursor_piece(cursor_piece), .box_x(box_x), .box_y(box_y),
    .verdict(verdict), .captured(captured), .done(done),
    .box_enable(box_enable), .check_start(check_start),
    .src_x(src_x), .src_y(src_y), .dst_x(dst_x), .dst_y(dst_y),
    .piece(piece), .current_player(current_player), .winning(winning),
    .wr_en(wr_en), .wr_x(wr_x), .wr_y(wr_y), .wr_piece(wr_piece)
  );

endmodule

`default_nettype wire

// ==== move_checker.sv ====
`timescale 1ns/1ps
`default_nettype none

module move_checker
  import game_pkg::*;
  import ctrl_pkg::*;
(
  input  logic clk,
  input  logic reset,
  input  logic check_start,
  input  logic [coord_w-1:0] src_x,
  input  logic [coord_w-1:0] src_y,
  input  logic [coord_w-1:0] dst_x,
  input  logic [coord_w-1:0] dst_y,
  input  logic [piece_w-1:0] mover,
  input  logic player,
  input  logic [piece_w-1:0] walk_piece,
  output logic [coord_w-1:0] walk_x,
  output logic [coord_w-1:0] walk_y,
  output verdict_e verdict,
  output logic [piece_w-1:0] captured,
  output logic done
);

  typedef enum logic {chk_idle, chk_walk} chk_state_e;

  chk_state_e state;
  piece_kind_e kind;
  verdict_e start_verdict;
  logic rook_walk;
  logic [coord_w-1:0] dx, dy, start_step_x, start_step_y, first_x, first_y;
  logic [coord_w-1:0] cur_x, cur_y, step_x, step_y, end_x, end_y, nxt_x, nxt_y;

  // idle reads the destination, walk reads the path cell
  assign walk_x = (state == chk_walk) ? cur_x : dst_x;
  assign walk_y = (state == chk_walk) ? cur_y : dst_y;

  assign kind = piece_kind_e'(mover[2:0]);
  assign dx = (dst_x > src_x) ? dst_x - src_x : src_x - dst_x;
  assign dy = (dst_y > src_y) ? dst_y - src_y : src_y - dst_y;
  // all ones acts as -1 on the coordinate width
  assign start_step_x = (dst_x > src_x) ? coord_w'(1) : (dst_x < src_x) ? '1 : '0;
  assign start_step_y = (dst_y > src_y) ? coord_w'(1) : (dst_y < src_y) ? '1 : '0;
  assign first_x = src_x + start_step_x;
  assign first_y = src_y + start_step_y;
  assign nxt_x = cur_x + step_x;
  assign nxt_y = cur_y + step_y;

  // first-cycle decision, rook_walk means the path still needs checking
  always_comb begin
    start_verdict = verdict_illegal;
    rook_walk = 1'b0;
    if ((src_x == dst_x && src_y == dst_y) ||
        (walk_piece != piece_empty && walk_piece[3] == player)) begin
      start_verdict = verdict_illegal;
    end else if (kind == kind_king) begin
      if (dx <= 1 && dy <= 1) start_verdict = verdict_legal;
    end else if (kind == kind_rook && (src_x == dst_x || src_y == dst_y)) begin
      if (first_x == dst_x && first_y == dst_y) start_verdict = verdict_legal;
      else rook_walk = 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= chk_idle;
      done <= 1'b0;
      verdict <= verdict_none;
      captured <= piece_empty;
    end else begin
      done <= 1'b0;
      case (state)
        chk_idle: begin
          if (check_start) begin
            captured <= walk_piece;
            cur_x <= first_x;
            cur_y <= first_y;
            step_x <= start_step_x;
            step_y <= start_step_y;
            end_x <= dst_x;
            end_y <= dst_y;
            if (rook_walk) begin
              state <= chk_walk;
              verdict <= verdict_none;
            end else begin
              done <= 1'b1;
              verdict <= start_verdict;
            end
          end
        end
        chk_walk: begin
          // one path cell per cycle, stop on the first occupied one
          if (walk_piece != piece_empty) begin
            state <= chk_idle;
            done <= 1'b1;
            verdict <= verdict_illegal;
          end else if (nxt_x == end_x && nxt_y == end_y) begin
            state <= chk_idle;
            done <= 1'b1;
            verdict <= verdict_legal;
          end else begin
            cur_x <= nxt_x;
            cur_y <= nxt_y;
          end
        end
        default: state <= chk_idle;
      endcase
    end
  end

  a_done_in_time: assert property (
    @(posedge clk) disable iff (reset)
    check_start |-> ##[1:8] done
  );

endmodule

`default_nettype wire

// ==== tb_game_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_game_top
  import game_pkg::*;
();

  localparam int tick_div = 1;
  localparam int half_period = 20;
  localparam int settle_cycles = 40;
  localparam int walk_steps = 40;

  logic clk;
  logic reset;
  logic up;
  logic down;
  logic left;
  logic right;
  logic select;
  logic deselect;
  logic [coord_w-1:0] box_x;
  logic [coord_w-1:0] box_y;
  logic [coord_w-1:0] probe_x;
  logic [coord_w-1:0] probe_y;
  logic [piece_w-1:0] piece;
  logic [piece_w-1:0] probe_piece;
  logic current_player;
  logic [1:0] winning;

  // reference board indexed by y*8+x
  logic [piece_w-1:0] model [board_dim*board_dim];
  logic [coord_w-1:0] exp_x;
  logic [coord_w-1:0] exp_y;
  logic exp_player;
  logic [1:0] exp_winning;
  logic [31:0] lfsr;
  logic cases_loaded;
  int errors;
  int tests;
  int failed_tests;
  int num_cases;
  int case_sx[$];
  int case_sy[$];
  int case_dx[$];
  int case_dy[$];
  int case_legal[$];
  int case_win[$];

  game_top #(.TICK_DIV(tick_div)) game_top_inst (
    .clk(clk), .reset(reset),
    .up(up), .down(down), .left(left), .right(right),
    .select(select), .deselect(deselect),
    .box_x(box_x), .box_y(box_y), .piece(piece),
    .current_player(current_player), .winning(winning),
    .probe_x(probe_x), .probe_y(probe_y), .probe_piece(probe_piece)
  );

  always #half_period clk = ~clk;

  // rooks at columns 0 and 7, king at 4, player one on the top row
  function automatic logic [piece_w-1:0] layout_code(input int x, input int y);
    logic [2:0] kind;
    kind = kind_empty;
    if (y == 0 || y == board_dim - 1) begin
      case (x)
        0, 7: kind = kind_rook;
        4: kind = kind_king;
        default: kind = kind_empty;
      endcase
    end
    if (kind == kind_empty) return piece_empty;
    return {logic'(y == board_dim - 1), kind};
  endfunction

  // galois form with taps 32 22 2 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    if (s[0]) return (s >> 1) ^ 32'h80200003;
    return s >> 1;
  endfunction

  task automatic take_bits(input int n, output int val);
    val = 0;
    for (int i = 0; i < n; i++) begin
      val = (val << 1) | int'(lfsr[0]);
      lfsr = lfsr_step(lfsr);
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] actual,
                             input logic [31:0] expected);
    if (actual !== expected) begin
      $display("FAIL %0t %s got %0h expected %0h", $time, name, actual, expected);
      errors++;
    end
  endtask

  task automatic report_test(input string name, input int err_before);
    tests++;
    if (errors == err_before) begin
      $display("test %s: pass", name);
    end else begin
      failed_tests++;
      $display("test %s: fail with %0d errors", name, errors - err_before);
    end
  endtask

  task automatic read_cases;
    int fd;
    int sx, sy, dx, dy, lg, wn;
    string line;
    fd = $fopen("game_cases.txt", "r");
    if (fd == 0) begin
      $display("could not open game_cases.txt");
      errors++;
      return;
    end
    while (!$feof(fd)) begin
      line = "";
      void'($fgets(line, fd));
      if (line.len() > 0 && line[0] != "#") begin
        if ($sscanf(line, "%d %d %d %d %d %d", sx, sy, dx, dy, lg, wn) == 6) begin
          case_sx.push_back(sx);
          case_sy.push_back(sy);
          case_dx.push_back(dx);
          case_dy.push_back(dy);
          case_legal.push_back(lg);
          case_win.push_back(wn);
        end
      end
    end
    $fclose(fd);
    num_cases = case_sx.size();
  endtask

  task automatic apply_reset;
    reset <= 1'b1;
    repeat (8) @(posedge clk);
    reset <= 1'b0;
    @(negedge clk);
  endtask

  task automatic reset_model;
    for (int i = 0; i < board_dim * board_dim; i++) begin
      model[i] = layout_code(i % board_dim, i / board_dim);
    end
    exp_x = '0;
    exp_y = '0;
    exp_player = 1'b0;
    exp_winning = 2'b00;
  endtask

  task automatic check_board;
    for (int y = 0; y < board_dim; y++) begin
      for (int x = 0; x < board_dim; x++) begin
        @(posedge clk);
        probe_x <= coord_w'(x);
        probe_y <= coord_w'(y);
        @(negedge clk);
        check_value($sformatf("probe_piece(%0d,%0d)", x, y), probe_piece,
                    model[y * board_dim + x]);
      end
    end
  endtask

  task automatic check_reset_state(input string name);
    int err_before;
    err_before = errors;
    check_value("box_x", box_x, 0);
    check_value("box_y", box_y, 0);
    check_value("current_player", current_player, 0);
    check_value("winning", winning, 0);
    check_value("piece", piece, 0);
    check_board();
    report_test(name, err_before);
  endtask

  // dir 0 is right, 1 left, 2 up, 3 down
  // the direction stays held until the box moves
  task automatic move_one(input int dir);
    int waited;
    waited = 0;
    @(posedge clk);
    case (dir)
      0: right <= 1'b1;
      1: left <= 1'b1;
      2: up <= 1'b1;
      default: down <= 1'b1;
    endcase
    do begin
      @(negedge clk);
      waited++;
    end while (box_x == exp_x && box_y == exp_y && waited < 8);
    if (box_x == exp_x && box_y == exp_y) begin
      $display("cursor did not move within 8 cycles at time %0t", $time);
      errors++;
    end
    case (dir)
      0: exp_x = exp_x + 1'b1;
      1: exp_x = exp_x - 1'b1;
      2: exp_y = exp_y + 1'b1;
      default: exp_y = exp_y - 1'b1;
    endcase
    check_value("box_x", box_x, exp_x);
    check_value("box_y", box_y, exp_y);
    @(posedge clk);
    right <= 1'b0;
    left <= 1'b0;
    up <= 1'b0;
    down <= 1'b0;
  endtask

  task automatic goto_cell(input int tx, input int ty);
    while (exp_x != coord_w'(tx)) move_one(0);
    while (exp_y != coord_w'(ty)) move_one(2);
  endtask

  task automatic press_select;
    @(posedge clk);
    select <= 1'b1;
    repeat (2) @(posedge clk);
    select <= 1'b0;
    @(negedge clk);
  endtask

  task automatic press_deselect;
    @(posedge clk);
    deselect <= 1'b1;
    repeat (2) @(posedge clk);
    deselect <= 1'b0;
    @(negedge clk);
  endtask

  task automatic wait_piece(input logic [piece_w-1:0] expected);
    int waited;
    waited = 0;
    while (piece !== expected && waited < settle_cycles) begin
      @(negedge clk);
      waited++;
    end
    check_value("piece", piece, expected);
  endtask

  // an illegal move changes nothing and runs out the whole window
  task automatic wait_turn_change(input logic old_player);
    int waited;
    waited = 0;
    while (current_player === old_player && winning === 2'b00 &&
           waited < settle_cycles) begin
      @(negedge clk);
      waited++;
    end
  endtask

  task automatic run_case(input int n);
    int src;
    int dst;
    int err_before;
    logic [piece_w-1:0] mover;
    logic [piece_w-1:0] target;
    err_before = errors;
    src = case_sy[n] * board_dim + case_sx[n];
    dst = case_dy[n] * board_dim + case_dx[n];
    mover = model[src];
    target = model[dst];
    if (mover == piece_empty || mover[3] != exp_player) begin
      $display("case %0d starts from a cell without a piece of player %0d", n + 1,
               exp_player);
      errors++;
    end
    goto_cell(case_sx[n], case_sy[n]);
    press_select();
    wait_piece(mover);
    goto_cell(case_dx[n], case_dy[n]);
    press_select();
    wait_turn_change(exp_player);
    if (case_legal[n] != 0) begin
      model[src] = piece_empty;
      model[dst] = mover;
      if (target[2:0] == kind_king && target[3] != exp_player) begin
        exp_winning = {1'b1, exp_player};
      end else begin
        exp_player = ~exp_player;
      end
    end else begin
      press_deselect();
      wait_piece(piece_empty);
    end
    if (case_win[n] != int'(exp_winning[1])) begin
      $display("case %0d win flag in the cases file disagrees with the board model", n + 1);
      errors++;
    end
    check_value("current_player", current_player, exp_player);
    check_value("winning", winning, exp_winning);
    check_board();
    report_test($sformatf("case %0d", n + 1), err_before);
  endtask

  initial begin
    wait (cases_loaded);
    repeat (num_cases * 2000) @(posedge clk);
    $display("watchdog stopped the run after %0d cycles", num_cases * 2000);
    $display("Result: FAILED");
    $finish;
  end

  initial begin
    int err_before;
    int dir;
    clk = 1'b0;
    reset = 1'b1;
    up = 1'b0;
    down = 1'b0;
    left = 1'b0;
    right = 1'b0;
    select = 1'b0;
    deselect = 1'b0;
    probe_x = '0;
    probe_y = '0;
    cases_loaded = 1'b0;
    errors = 0;
    tests = 0;
    failed_tests = 0;
    lfsr = 32'hed9c8b8c;
    read_cases();
    if (num_cases == 0) begin
      $display("no cases were read from game_cases.txt");
      errors++;
    end
    cases_loaded = 1'b1;
    apply_reset();
    reset_model();
    check_reset_state("reset_state");

    err_before = errors;
    for (int i = 0; i < walk_steps; i++) begin
      take_bits(2, dir);
      move_one(dir);
    end
    report_test("random_walk", err_before);

    err_before = errors;
    // empty cell, then the opponent king
    goto_cell(3, 3);
    press_select();
    wait_piece(piece_empty);
    goto_cell(4, 7);
    press_select();
    wait_piece(piece_empty);
    check_value("current_player", current_player, exp_player);
    // own rook picked up and put back
    goto_cell(0, 0);
    press_select();
    wait_piece(model[0]);
    press_deselect();
    wait_piece(piece_empty);
    check_value("current_player", current_player, exp_player);
    report_test("select_rules", err_before);

    for (int n = 0; n < num_cases && !exp_winning[1]; n++) begin
      run_case(n);
    end

    err_before = errors;
    if (!exp_winning[1]) begin
      $display("the case sequence did not end the game");
      errors++;
    end
    repeat (3) begin
      press_select();
      repeat (4) @(posedge clk);
    end
    @(negedge clk);
    check_value("winning", winning, exp_winning);
    check_value("current_player", current_player, exp_player);
    check_board();
    report_test("game_over", err_before);

    @(posedge clk);
    apply_reset();
    reset_model();
    check_reset_state("reset_after_game");

    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0 && failed_tests == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== tick_divider.sv ====
`timescale 1ns/1ps
`default_nettype none

module tick_divider #(
  parameter int TICK_DIV = 12500000
) (
  input  logic clk,
  input  logic reset,
  output logic tick
);

  localparam int cnt_w = (TICK_DIV < 1) ? 1 : $clog2(TICK_DIV + 1);
  localparam logic [cnt_w-1:0] cnt_max = cnt_w'(TICK_DIV);

  logic [cnt_w-1:0] count;

  // one tick every TICK_DIV+1 clocks
  always_ff @(posedge clk) begin
    if (reset) begin
      count <= '0;
      tick <= 1'b0;
    end else if (count == cnt_max) begin
      count <= '0;
      tick <= 1'b1;
    end else begin
      count <= count + 1'b1;
      tick <= 1'b0;
    end
  end

endmodule

`default_nettype wire
